//--- dv/xreg_patterns.mem
// op_reg_bytesel_data_test; op 1 write, 2 read-check, 3 poll idle, 4 set inputs,
// 5 check intr mask, 6 timer wait, 7 vram stall, 8 check intr clear
2_0_1_0F_1
2_0_0_00_1
1_6_0_12_1
1_6_1_34_1
2_6_0_12_1
2_6_1_34_1
1_4_0_56_1
1_4_1_78_1
2_4_1_78_1
1_0_1_05_1
2_0_1_05_1
1_0_1_0F_1
1_8_0_00_2
1_8_1_03_2
1_9_0_00_2
1_9_1_10_2
1_A_0_AB_2
1_A_1_CD_2
3_0_0_00_2
1_A_0_12_2
1_A_1_34_2
3_0_0_00_2
1_0_1_03_2
1_A_0_56_2
1_A_1_78_2
3_0_0_00_2
1_0_1_0F_2
2_9_1_19_2
2_9_0_00_2
1_6_0_00_3
1_6_1_03_3
1_7_0_00_3
1_7_1_10_3
3_0_0_00_3
2_A_0_AB_3
2_A_1_CD_3
3_0_0_00_3
2_A_0_12_3
2_A_1_34_3
3_0_0_00_3
2_A_0_A5_3
2_A_1_78_3
3_0_0_00_3
2_A_0_A5_3
2_A_1_43_3
1_4_0_00_4
1_4_1_20_4
1_5_0_11_4
1_5_1_22_4
3_0_0_00_4
1_5_0_33_4
1_5_1_44_4
3_0_0_00_4
2_4_1_22_4
1_3_0_00_4
1_3_1_20_4
3_0_0_00_4
2_5_0_11_4
2_5_1_22_4
3_0_0_00_4
2_5_0_33_4
2_5_1_44_4
3_0_0_00_4
2_5_0_3C_4
2_5_1_22_4
7_0_0_01_5
1_A_0_00_5
1_A_1_00_5
2_0_0_80_5
7_0_0_00_5
3_0_0_00_5
4_0_0_30_5
2_0_0_06_5
4_0_0_0A_6
1_1_0_05_6
5_0_0_05_6
2_1_0_05_6
2_1_1_0A_6
1_1_1_3C_6
8_0_0_0C_6
6_0_0_64_6

//--- filelist.f
+incdir+include
verilog/xreg_bus_pkg.sv
verilog/xreg_mem_pkg.sv
verilog/bus_sync.sv
verilog/tick_timer.sv
verilog/mem_access_port.sv
verilog/xreg_regfile.sv
verilog/xreg_top.sv
dv/xreg_tb.sv

//--- Makefile
# Verilator build and run of the register interface testbench

VERILATOR ?= verilator
TOP       ?= xreg_tb
RTL_TOP   ?= xreg_top
TIMER_DIV ?= 10
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-GTIMER_DIV=$(TIMER_DIV) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) \
		-GTIMER_DIV=$(TIMER_DIV)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/xreg_tb.sv
// testbench for xreg_top: replays bus operations from the pattern file against a memory model
`include "xreg_consts.svh"

module xreg_tb #(
    parameter int unsigned TIMER_DIV = `XREG_TIMER_DIV
);
    import xreg_bus_pkg::*;
    import xreg_mem_pkg::*;

    localparam int MAX_PAT = 128;
    localparam logic [15:0] VRAM_FILL = 16'hA55A;   // model preload is address xor this
    localparam logic [15:0] XR_FILL   = 16'h3C00;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       bus_cs_n_i;
    logic       bus_rd_nwr_i;
    logic [3:0] bus_reg_num_i;
    logic       bus_bytesel_i;
    byte_t      bus_data_i;
    byte_t      bus_data_o;
    vram_req_t  vram_req;
    logic       vram_ack;
    word_t      vram_rdata;
    logic [3:0] wrmask;
    xr_req_t    xr_req;
    logic       xr_ack;
    word_t      xr_rdata;
    logic       h_blank_i;
    logic       v_blank_i;
    intr_t      intr_status_i;
    intr_t      intr_mask_o;
    intr_t      intr_clear_o;

    logic [23:0] pats [MAX_PAT];    // op, reg, bytesel, data, test
    int          n_pat;
    logic        loaded = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          seed = 62949;
    int          cycle = 0;
    logic        stall = 1'b0;      // holds back vram acks
    logic        vram_pend = 1'b0;
    logic        xr_pend = 1'b0;
    int          vram_wait;
    int          xr_wait;
    word_t       vram_mem [256];
    word_t       xr_mem [256];
    intr_t       clear_val;
    int          clear_len = 0;

    xreg_top #(.TIMER_DIV(TIMER_DIV)) uut (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_data_o,
        .vram_req_o(vram_req), .vram_ack_i(vram_ack), .vram_rdata_i(vram_rdata),
        .wrmask_o(wrmask),
        .xr_req_o(xr_req), .xr_ack_i(xr_ack), .xr_rdata_i(xr_rdata),
        .h_blank_i, .v_blank_i, .intr_status_i, .intr_mask_o, .intr_clear_o
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // vram model, acks 1 to 4 cycles after sel
    always @(negedge clk) begin
        if (vram_ack) begin
            vram_ack = 1'b0;
        end else if (vram_req.sel && !stall) begin
            if (!vram_pend) begin
                vram_pend = 1'b1;
                vram_wait = 1 + ($random(seed) & 3);
            end
            vram_wait--;
            if (vram_wait == 0) begin
                vram_pend = 1'b0;
                vram_ack  = 1'b1;
                if (vram_req.wr) begin
                    for (int n = 0; n < 4; n++) begin
                        if (wrmask[n]) begin
                            vram_mem[vram_req.addr[7:0]][4*n +: 4] = vram_req.data[4*n +: 4];
                        end
                    end
                end else begin
                    vram_rdata = vram_mem[vram_req.addr[7:0]];
                end
            end
        end
    end

    always @(negedge clk) begin
        if (xr_ack) begin
            xr_ack = 1'b0;
        end else if (xr_req.sel) begin
            if (!xr_pend) begin
                xr_pend = 1'b1;
                xr_wait = 1 + ($random(seed) & 3);
            end
            xr_wait--;
            if (xr_wait == 0) begin
                xr_pend = 1'b0;
                xr_ack  = 1'b1;
                if (xr_req.wr) begin
                    xr_mem[xr_req.addr[7:0]] = xr_req.data;
                end else begin
                    xr_rdata = xr_mem[xr_req.addr[7:0]];
                end
            end
        end
    end

    // width and value of the interrupt clear pulse
    always @(negedge clk) begin
        if (intr_clear_o != '0) begin
            clear_val = intr_clear_o;
            clear_len++;
        end
    end

    task automatic bus_access(input logic rd, input logic [3:0] rn, input logic bs,
                              input byte_t wdata, output byte_t rdata);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = rd;
        bus_reg_num_i = rn;
        bus_bytesel_i = bs;
        bus_data_i    = wdata;
        repeat (6) @(negedge clk);
        rdata      = bus_data_o;    // sampled before cs_n releases
        bus_cs_n_i = 1'b1;
        repeat (8) @(negedge clk);
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic poll_idle();
        byte_t b;
        do begin
            bus_access(1'b1, SYS_CTRL, 1'b0, 8'h00, b);
        end while (b[7]);
    endtask

    task automatic check_timer(input int gap, input int test);
        byte_t hi;
        byte_t lo;
        word_t t1;
        word_t t2;
        int    c1;
        int    c2;
        int    diff;
        int    exp;
        bus_access(1'b1, TIMER, 1'b0, 8'h00, hi);
        c1 = cycle;
        bus_access(1'b1, TIMER, 1'b1, 8'h00, lo);
        t1 = {hi, lo};
        repeat (gap) @(negedge clk);
        bus_access(1'b1, TIMER, 1'b0, 8'h00, hi);
        c2 = cycle;
        bus_access(1'b1, TIMER, 1'b1, 8'h00, lo);
        t2   = {hi, lo};
        diff = int'(word_t'(t2 - t1));
        exp  = (c2 - c1) / TIMER_DIV;
        checks++;
        assert (diff >= exp - 1 && diff <= exp + 1) else begin
            errors++;
            $display("FAILED test %0d timer: expected %0d, actual %0d", test, exp, diff);
        end
    endtask

    initial begin
        logic [3:0] op;
        logic [3:0] rn;
        logic       bs;
        byte_t      d;
        int         test;
        byte_t      rb;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_reg_num_i = '0;
        bus_bytesel_i = 1'b0;
        bus_data_i    = '0;
        vram_ack      = 1'b0;
        vram_rdata    = '0;
        xr_ack        = 1'b0;
        xr_rdata      = '0;
        h_blank_i     = 1'b0;
        v_blank_i     = 1'b0;
        intr_status_i = '0;
        reset_i       = 1'b1;
        for (int i = 0; i < 256; i++) begin
            vram_mem[i] = 16'(i) ^ VRAM_FILL;
            xr_mem[i]   = 16'(i) ^ XR_FILL;
        end
        for (int i = 0; i < MAX_PAT; i++) begin
            pats[i] = '0;
        end
        $readmemh("dv/xreg_patterns.mem", pats);
        n_pat = 0;
        while (n_pat < MAX_PAT && pats[n_pat][23:20] != 4'h0) begin
            n_pat++;
        end
        loaded = 1'b1;
        repeat (2) @(negedge clk);
        reset_i = 1'b0;
        repeat (4) @(negedge clk);
        for (int i = 0; i < n_pat; i++) begin
            {op, rn} = pats[i][23:16];
            bs   = pats[i][12];
            d    = pats[i][11:4];
            test = pats[i][3:0];
            case (op)
                4'h1: bus_access(1'b0, rn, bs, d, rb);
                4'h2: begin
                    bus_access(1'b1, rn, bs, 8'h00, rb);
                    check_byte($sformatf("test %0d reg %0d byte %0d", test, rn, bs), d, rb);
                end
                4'h3: poll_idle();
                4'h4: begin
                    h_blank_i     = d[5];
                    v_blank_i     = d[4];
                    intr_status_i = d[3:0];
                end
                4'h5: check_byte($sformatf("test %0d intr_mask", test), d, 8'(intr_mask_o));
                4'h6: check_timer(d, test);
                4'h7: stall = d[0];
                4'h8: begin
                    check_byte($sformatf("test %0d intr_clear", test), d, 8'(clear_val));
                    checks++;
                    assert (clear_len == 1) else begin
                        errors++;
                        $display("test %0d: interrupt clear pulse lasted %0d cycles", test,
                                 clear_len);
                    end
                    clear_len = 0;
                end
                default: begin
                    errors++;
                    $display("pattern %0d has an unknown operation code %h", i, op);
                end
            endcase
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // budget of 40 cycles per pattern
    initial begin
        wait (loaded);
        repeat (n_pat * 40 + 200) @(posedge clk);
        $display("watchdog expired before the patterns finished");
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog/xreg_top.sv
// register interface top: bus synchronizer, timer, register block and the two memory ports
`default_nettype none

`include "xreg_consts.svh"

module xreg_top #(
    parameter int unsigned TIMER_DIV = `XREG_TIMER_DIV
) (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    bus_cs_n_i,
    input  wire logic                    bus_rd_nwr_i,
    input  wire logic [`XREG_REG_W-1:0]  bus_reg_num_i,
    input  wire logic                    bus_bytesel_i,
    input  wire xreg_bus_pkg::byte_t     bus_data_i,
    output      xreg_bus_pkg::byte_t     bus_data_o,
    output      xreg_mem_pkg::vram_req_t vram_req_o,
    input  wire logic                    vram_ack_i,
    input  wire xreg_bus_pkg::word_t     vram_rdata_i,
    output      logic [`XREG_NIB_W-1:0]  wrmask_o,
    output      xreg_mem_pkg::xr_req_t   xr_req_o,
    input  wire logic                    xr_ack_i,
    input  wire xreg_bus_pkg::word_t     xr_rdata_i,
    input  wire logic                    h_blank_i,
    input  wire logic                    v_blank_i,
    input  wire xreg_bus_pkg::intr_t     intr_status_i,
    output      xreg_bus_pkg::intr_t     intr_mask_o,
    output      xreg_bus_pkg::intr_t     intr_clear_o
);
    import xreg_bus_pkg::*;
    import xreg_mem_pkg::*;

    bus_evt_t  bus_evt;
    word_t     timer_val;
    logic      vram_issue;
    logic      xr_issue;
    vram_req_t vram_payload;
    xr_req_t   xr_payload;
    mem_rsp_t  vram_rsp;
    mem_rsp_t  xr_rsp;
    logic      vram_busy;
    logic      xr_busy;

    bus_sync sync (
        .clk, .reset_i, .bus_cs_n_i, .bus_rd_nwr_i, .bus_reg_num_i, .bus_bytesel_i,
        .bus_data_i, .bus_evt_o(bus_evt)
    );

    tick_timer #(.DIV(TIMER_DIV)) tick (
        .clk, .reset_i, .bus_evt_i(bus_evt), .timer_o(timer_val)
    );

    xreg_regfile regs (
        .clk, .reset_i, .bus_evt_i(bus_evt), .timer_i(timer_val),
        .vram_rsp_i(vram_rsp), .xr_rsp_i(xr_rsp),
        .vram_busy_i(vram_busy), .xr_busy_i(xr_busy),
        .h_blank_i, .v_blank_i, .intr_status_i,
        .vram_issue_o(vram_issue), .vram_req_o(vram_payload),
        .xr_issue_o(xr_issue), .xr_req_o(xr_payload),
        .bus_data_o, .intr_mask_o, .intr_clear_o
    );

    mem_access_port #(.req_t(vram_req_t)) vram_port (
        .clk, .reset_i, .issue_i(vram_issue), .payload_i(vram_payload),
        .ack_i(vram_ack_i), .rdata_i(vram_rdata_i),
        .req_o(vram_req_o), .rsp_o(vram_rsp), .busy_o(vram_busy)
    );

    mem_access_port #(.req_t(xr_req_t)) xr_port (
        .clk, .reset_i, .issue_i(xr_issue), .payload_i(xr_payload),
        .ack_i(xr_ack_i), .rdata_i(xr_rdata_i),
        .req_o(xr_req_o), .rsp_o(xr_rsp), .busy_o(xr_busy)
    );

    assign wrmask_o = vram_req_o.wrmask;    // nibble enables travel with the request

endmodule

`default_nettype wire

//--- verilog/xreg_regfile.sv
// register block: decodes bus bytes, issues vram and xr requests, muxes readback
`default_nettype none

`include "xreg_consts.svh"

module xreg_regfile (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire xreg_bus_pkg::bus_evt_t  bus_evt_i,
    input  wire xreg_bus_pkg::word_t     timer_i,
    input  wire xreg_mem_pkg::mem_rsp_t  vram_rsp_i,
    input  wire xreg_mem_pkg::mem_rsp_t  xr_rsp_i,
    input  wire logic                    vram_busy_i,
    input  wire logic                    xr_busy_i,
    input  wire logic                    h_blank_i,
    input  wire logic                    v_blank_i,
    input  wire xreg_bus_pkg::intr_t     intr_status_i,
    output      logic                    vram_issue_o,
    output      xreg_mem_pkg::vram_req_t vram_req_o,
    output      logic                    xr_issue_o,
    output      xreg_mem_pkg::xr_req_t   xr_req_o,
    output      xreg_bus_pkg::byte_t     bus_data_o,
    output      xreg_bus_pkg::intr_t     intr_mask_o,
    output      xreg_bus_pkg::intr_t     intr_clear_o
);
    import xreg_bus_pkg::*;
    import xreg_mem_pkg::*;

    addr_t                  rd_xaddr_q;
    addr_t                  wr_xaddr_q;
    addr_t                  rd_addr_q;
    addr_t                  wr_addr_q;
    word_t                  rd_incr_q;
    word_t                  wr_incr_q;
    word_t                  xdata_q;        // xr pre-read result
    word_t                  data_q;         // vram pre-read result
    byte_t                  xdata_even_q;
    byte_t                  data_even_q;
    logic [`XREG_NIB_W-1:0] wrmask_q;
    intr_t                  intr_mask_q;
    intr_t                  intr_clear_q;
    logic                   wr_odd;
    logic                   rd_odd;
    word_t                  rd_word;

    function automatic word_t set_byte(word_t w, logic odd, byte_t b);
        return odd ? {w[15:8], b} : {b, w[7:0]};
    endfunction

    assign wr_odd = bus_evt_i.wr_stb & bus_evt_i.bytesel;
    assign rd_odd = bus_evt_i.rd_stb & bus_evt_i.bytesel;

    // requests go out with the strobe, the port registers them
    always_comb begin
        vram_issue_o = 1'b0;
        xr_issue_o   = 1'b0;
        vram_req_o   = '{sel: 1'b1, wr: 1'b0, wrmask: wrmask_q, addr: rd_addr_q,
                         data: {data_even_q, bus_evt_i.data}};
        xr_req_o     = '{sel: 1'b1, wr: 1'b0, addr: rd_xaddr_q,
                         data: {xdata_even_q, bus_evt_i.data}};
        if (wr_odd) begin
            case (bus_evt_i.reg_num)
                RD_XADDR: begin
                    xr_issue_o    = 1'b1;
                    xr_req_o.addr = {rd_xaddr_q[15:8], bus_evt_i.data};
                end
                XDATA: begin
                    xr_issue_o    = 1'b1;
                    xr_req_o.wr   = 1'b1;
                    xr_req_o.addr = wr_xaddr_q;
                end
                RD_ADDR: begin
                    vram_issue_o    = 1'b1;
                    vram_req_o.addr = {rd_addr_q[15:8], bus_evt_i.data};
                end
                DATA, DATA_2: begin
                    vram_issue_o    = 1'b1;
                    vram_req_o.wr   = 1'b1;
                    vram_req_o.addr = wr_addr_q;
                end
                default: ;
            endcase
        end
        if (rd_odd && bus_evt_i.reg_num == XDATA) begin
            xr_issue_o = 1'b1;                  // next xr pre-read
        end
        if (rd_odd && (bus_evt_i.reg_num == DATA || bus_evt_i.reg_num == DATA_2)) begin
            vram_issue_o = 1'b1;                // next vram pre-read
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_xaddr_q   <= '0;
            wr_xaddr_q   <= '0;
            rd_addr_q    <= '0;
            wr_addr_q    <= '0;
            rd_incr_q    <= '0;
            wr_incr_q    <= '0;
            xdata_q      <= '0;
            data_q       <= '0;
            xdata_even_q <= '0;
            data_even_q  <= '0;
            wrmask_q     <= `XREG_WRMASK_RST;
            intr_mask_q  <= '0;
            intr_clear_q <= '0;
        end else begin
            intr_clear_q <= '0;
            if (vram_rsp_i.done) begin
                if (vram_rsp_i.was_wr) begin
                    wr_addr_q <= wr_addr_q + wr_incr_q;
                end else begin
                    data_q    <= vram_rsp_i.rdata;
                    rd_addr_q <= rd_addr_q + rd_incr_q;
                end
            end
            if (xr_rsp_i.done) begin
                if (xr_rsp_i.was_wr) begin
                    wr_xaddr_q <= wr_xaddr_q + 1'b1;
                end else begin
                    xdata_q    <= xr_rsp_i.rdata;
                    rd_xaddr_q <= rd_xaddr_q + 1'b1;
                end
            end
            // a bus write lands after the done update above
            if (bus_evt_i.wr_stb) begin
                case (bus_evt_i.reg_num)
                    SYS_CTRL: if (bus_evt_i.bytesel) begin
                        wrmask_q <= bus_evt_i.data[`XREG_NIB_W-1:0];
                    end
                    INT_CTRL: if (!bus_evt_i.bytesel) begin
                        intr_mask_q <= bus_evt_i.data[`XREG_INTR_W-1:0];
                    end else begin
                        intr_clear_q <= bus_evt_i.data[`XREG_INTR_W-1:0];
                    end
                    RD_XADDR: rd_xaddr_q <= set_byte(rd_xaddr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    WR_XADDR: wr_xaddr_q <= set_byte(wr_xaddr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    RD_INCR:  rd_incr_q  <= set_byte(rd_incr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    RD_ADDR:  rd_addr_q  <= set_byte(rd_addr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    WR_INCR:  wr_incr_q  <= set_byte(wr_incr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    WR_ADDR:  wr_addr_q  <= set_byte(wr_addr_q, bus_evt_i.bytesel, bus_evt_i.data);
                    XDATA: if (!bus_evt_i.bytesel) begin
                        xdata_even_q <= bus_evt_i.data;
                    end
                    DATA, DATA_2: if (!bus_evt_i.bytesel) begin
                        data_even_q <= bus_evt_i.data;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (bus_evt_i.reg_num)
            SYS_CTRL: rd_word = {vram_busy_i | xr_busy_i, 4'b0, h_blank_i, v_blank_i,
                                 5'b0, wrmask_q};
            INT_CTRL: rd_word = {4'b0, intr_mask_q, 4'b0, intr_status_i};
            TIMER:    rd_word = timer_i;
            RD_XADDR: rd_word = rd_xaddr_q;
            WR_XADDR: rd_word = wr_xaddr_q;
            XDATA:    rd_word = xdata_q;
            RD_INCR:  rd_word = rd_incr_q;
            RD_ADDR:  rd_word = rd_addr_q;
            WR_INCR:  rd_word = wr_incr_q;
            WR_ADDR:  rd_word = wr_addr_q;
            default:  rd_word = data_q;         // DATA, DATA_2 and unused
        endcase
    end

    assign bus_data_o   = bus_evt_i.bytesel ? rd_word[7:0] : rd_word[15:8];
    assign intr_mask_o  = intr_mask_q;
    assign intr_clear_o = intr_clear_q;

    // relies on single cycle write strobes from the synchronizer
    a_clear_pulse: assert property (@(posedge clk) disable iff (reset_i)
        intr_clear_o != '0 |=> intr_clear_o == '0);

endmodule

`default_nettype wire

//--- verilog/mem_access_port.sv
// holds one memory request until acknowledged and returns its response, for any payload type
`default_nettype none

module mem_access_port #(
    parameter type req_t = xreg_mem_pkg::xr_req_t
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   issue_i,        // load payload and raise sel
    input  wire req_t                   payload_i,
    input  wire logic                   ack_i,
    input  wire xreg_bus_pkg::word_t    rdata_i,        // valid with ack
    output      req_t                   req_o,
    output      xreg_mem_pkg::mem_rsp_t rsp_o,
    output      logic                   busy_o
);
    import xreg_bus_pkg::*;

    req_t  payload_q;
    logic  sel_q;
    logic  done_q;
    logic  was_wr_q;
    word_t rdata_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= sel_q & ack_i;
            if (issue_i) begin
                sel_q <= 1'b1;          // a new issue wins over the ack
            end else if (ack_i) begin
                sel_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            payload_q <= payload_i;    // replaces a pending request
        end
        if (sel_q && ack_i) begin
            was_wr_q <= payload_q.wr;
            rdata_q  <= rdata_i;
        end
    end

    always_comb begin
        req_o     = payload_q;
        req_o.sel = sel_q;
    end

    always_comb begin
        rsp_o.done   = done_q;
        rsp_o.was_wr = was_wr_q;
        rsp_o.rdata  = rdata_q;
    end

    assign busy_o = sel_q;

    // memory must not drop a request or answer one never made
    a_sel_held: assert property (@(posedge clk) disable iff (reset_i)
        sel_q && !ack_i |=> sel_q);
    a_ack_with_sel: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> sel_q);

endmodule

`default_nettype wire

//--- verilog/tick_timer.sv
// free running 1/10 ms timer; low byte is latched when the high byte is read
`default_nettype none

`include "xreg_consts.svh"

module tick_timer #(
    parameter int unsigned DIV = `XREG_TIMER_DIV    // clocks per count
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire xreg_bus_pkg::bus_evt_t bus_evt_i,
    output      xreg_bus_pkg::word_t    timer_o
);
    import xreg_bus_pkg::*;

    localparam int unsigned DIV_W = (DIV > 1) ? $clog2(DIV) : 1;

    logic [DIV_W-1:0] div_q;
    word_t            count_q;
    byte_t            low_latch_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            div_q       <= '0;
            count_q     <= '0;
            low_latch_q <= '0;
        end else begin
            if (div_q == DIV_W'(DIV - 1)) begin
                div_q   <= '0;
                count_q <= count_q + 1'b1;
            end else begin
                div_q   <= div_q + 1'b1;
            end
            if (bus_evt_i.rd_stb && !bus_evt_i.bytesel && bus_evt_i.reg_num == TIMER) begin
                low_latch_q <= count_q[7:0];   // pairs with the high byte just read
            end
        end
    end

    assign timer_o = {count_q[15:8], low_latch_q};

endmodule

`default_nettype wire

//--- verilog/bus_sync.sv
// synchronizes the asynchronous cpu bus pins and turns chip select edges into byte strobes
`default_nettype none

`include "xreg_consts.svh"

module bus_sync (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_cs_n_i,
    input  wire logic                   bus_rd_nwr_i,
    input  wire logic [`XREG_REG_W-1:0] bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xreg_bus_pkg::byte_t    bus_data_i,
    output      xreg_bus_pkg::bus_evt_t bus_evt_o
);
    import xreg_bus_pkg::*;

    typedef struct packed {
        logic     cs_n;
        logic     rd_nwr;
        reg_num_e reg_num;
        logic     bytesel;
        byte_t    data;
    } pins_t;

    localparam pins_t PINS_IDLE = '{cs_n: 1'b1, rd_nwr: 1'b1, reg_num: SYS_CTRL,
                                    bytesel: 1'b0, data: '0};

    pins_t    pins;
    pins_t    sync_q [`XREG_SYNC_STAGES];
    pins_t    cur;                      // last sync stage
    logic     cs_n_last_q;
    logic     rd_nwr_last_q;            // direction of the access that is ending
    logic     wr_edge;
    logic     rd_edge;
    bus_evt_t evt_q;

    always_comb begin
        pins.cs_n    = bus_cs_n_i;
        pins.rd_nwr  = bus_rd_nwr_i;
        pins.reg_num = reg_num_e'(bus_reg_num_i);
        pins.bytesel = bus_bytesel_i;
        pins.data    = bus_data_i;
    end

    assign cur     = sync_q[`XREG_SYNC_STAGES-1];
    assign wr_edge = cs_n_last_q & ~cur.cs_n & ~cur.rd_nwr;    // write starts
    assign rd_edge = ~cs_n_last_q & cur.cs_n & rd_nwr_last_q;  // read has ended

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `XREG_SYNC_STAGES; i++) begin
                sync_q[i] <= PINS_IDLE;
            end
            cs_n_last_q   <= 1'b1;
            rd_nwr_last_q <= 1'b1;
            evt_q         <= '0;
        end else begin
            sync_q[0] <= pins;
            for (int i = 1; i < `XREG_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            cs_n_last_q   <= cur.cs_n;
            rd_nwr_last_q <= cur.rd_nwr;
            evt_q.wr_stb  <= wr_edge;
            evt_q.rd_stb  <= rd_edge;
            // fields follow the pins only while selected, so they hold past cs_n rising
            if (!cur.cs_n) begin
                evt_q.reg_num <= cur.reg_num;
                evt_q.bytesel <= cur.bytesel;
                evt_q.data    <= cur.data;
            end
        end
    end

    assign bus_evt_o = evt_q;

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(bus_evt_o.wr_stb && bus_evt_o.rd_stb));

endmodule

`default_nettype wire

//--- verilog/xreg_mem_pkg.sv
// memory side types: vram and xr request payloads and the shared response
`include "xreg_consts.svh"

package xreg_mem_pkg;

    typedef struct packed {
        logic                   sel;    // request outstanding
        logic                   wr;     // 1 write, 0 read
        logic [`XREG_NIB_W-1:0] wrmask; // nibble enables for writes
        xreg_bus_pkg::addr_t    addr;
        xreg_bus_pkg::word_t    data;
    } vram_req_t;

    typedef struct packed {
        logic                sel;
        logic                wr;
        xreg_bus_pkg::addr_t addr;
        xreg_bus_pkg::word_t data;
    } xr_req_t;

    // done pulses one cycle when the memory acknowledges
    typedef struct packed {
        logic                done;
        logic                was_wr;
        xreg_bus_pkg::word_t rdata;     // valid with done on reads
    } mem_rsp_t;

endpackage

//--- verilog/xreg_bus_pkg.sv
// cpu bus side types: bus bytes and words, register numbers, synchronized bus event
`include "xreg_consts.svh"

package xreg_bus_pkg;

    typedef logic [`XREG_BYTE_W-1:0] byte_t;
    typedef logic [`XREG_WORD_W-1:0] word_t;
    typedef logic [`XREG_WORD_W-1:0] addr_t;
    typedef logic [`XREG_INTR_W-1:0] intr_t;

    // 12 to 15 are unused and read back as DATA
    typedef enum logic [`XREG_REG_W-1:0] {
        SYS_CTRL = 4'h0,                // busy, blanks, write mask
        INT_CTRL = 4'h1,                // interrupt mask and clear
        TIMER    = 4'h2,                // 1/10 ms timer
        RD_XADDR = 4'h3,
        WR_XADDR = 4'h4,
        XDATA    = 4'h5,
        RD_INCR  = 4'h6,
        RD_ADDR  = 4'h7,
        WR_INCR  = 4'h8,
        WR_ADDR  = 4'h9,
        DATA     = 4'hA,
        DATA_2   = 4'hB                 // alias of DATA
    } reg_num_e;

    typedef struct packed {
        logic     wr_stb;               // start of a write byte
        logic     rd_stb;               // end of a read byte
        reg_num_e reg_num;
        logic     bytesel;              // 0 even, 1 odd
        byte_t    data;
    } bus_evt_t;

endpackage

//--- include/xreg_consts.svh
// widths, sizes and reset values shared by the register interface; include where needed
`ifndef XREG_CONSTS_SVH
`define XREG_CONSTS_SVH

`define XREG_WORD_W       16            // register and memory word
`define XREG_BYTE_W       8             // cpu bus byte
`define XREG_NIB_W        4             // vram nibble write mask
`define XREG_INTR_W       4             // interrupt sources

`define XREG_NUM_REGS     16            // registers on the cpu bus
`define XREG_REG_W        $clog2(`XREG_NUM_REGS)

// clocks per timer count, default is short for simulation
// a build sets the real 1/10 ms value through the TIMER_DIV parameter of xreg_top
`define XREG_TIMER_DIV    10

`define XREG_SYNC_STAGES  2             // flops per bus pin

`define XREG_WRMASK_RST   4'b1111       // all nibbles written

`endif
